//--- bench/rvfi_patterns.hex
// valid insn pc_rdata rs1_rdata rs2_rdata rd_addr rd_wdata pc_wdata trap
// then expected mismatch, unknown, field_err (bit 3 trap, 2 pc_wdata, 1 rd_wdata, 0 rd_addr)
1 60211093 00001000 0000000f 00000000 01 00000004 00001004 0 0 0 0
1 60211093 00001004 ffffffff 00000000 01 00000020 00001008 0 0 0 0
1 60011093 00001008 00010000 00000000 01 0000000f 0000100c 0 0 0 0
1 60011093 0000100c 00000000 00000000 01 00000020 00001010 0 0 0 0
1 60111093 00001010 00010000 00000000 01 00000010 00001014 0 0 0 0
1 60111093 00001014 00000000 00000000 01 00000020 00001018 0 0 0 0
1 60111093 00001018 80000000 00000000 01 0000001f 0000101c 0 0 0 0
1 60111093 0000101c 00000100 00000000 01 00000008 00001020 0 0 0 0
1 403170b3 00001020 f0f0f0f0 ff00ff00 01 00f000f0 00001024 0 0 0 0
1 403160b3 00001024 f0f0f0f0 ff00ff00 01 f0fff0ff 00001028 0 0 0 0
1 403140b3 00001028 f0f0f0f0 ff00ff00 01 f00ff00f 0000102c 0 0 0 0
1 403170b3 0000102c ffffffff 00000000 01 ffffffff 00001030 0 0 0 0
1 403160b3 00001030 00000000 ffffffff 01 00000000 00001034 0 0 0 0
1 403140b3 00001034 00000000 00000000 01 ffffffff 00001038 0 0 0 0
1 403140b3 00001038 ffffffff ffffffff 01 ffffffff 0000103c 0 0 0 0
1 60211013 0000103c 000000ff 00000000 00 00000000 00001040 0 0 0 0
1 60211013 00001040 000000ff 00000000 00 00000008 00001044 0 1 0 2
1 60211093 00002000 00000003 00000000 01 00000003 00002004 0 1 0 2
1 60011093 00002004 00000001 00000000 01 0000001f 0000200c 0 1 0 4
1 403170b3 00002008 0000ffff 000000ff 01 0000ff00 0000200c 1 1 0 8
1 60211093 0000200c 00000003 00000000 02 00000002 00002010 0 1 0 1
1 403140b3 00002010 12345678 12345678 01 00000000 00002018 0 1 0 6
1 00000013 00003000 00000000 00000000 00 00000000 00003004 0 0 1 0
0 60211093 00003004 0000000f 00000000 01 00000004 00003008 0 0 0 0
1 60301013 00003008 00000001 00000000 01 00000000 0000300c 0 0 1 0
0 00000000 00000000 00000000 00000000 00 00000000 00000000 0 0 0 0
1 60111093 0000300c 00000001 00000000 01 00000000 00003010 0 0 0 0
1 60011093 00003010 40000000 00000000 01 00000001 00003014 0 0 0 0

//--- compile.f
src/bitmanip_pkg.sv
src/insn_pcnt_checker.sv
src/insn_zcount_checker.sv
src/insn_logic_checker.sv
src/spec_select.sv
src/retire_compare.sv
src/bitmanip_spec_top.sv
bench/tb_clock.sv
bench/tb_bitmanip_spec.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_bitmanip_spec
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_bitmanip_spec.sv
module tb_bitmanip_spec;

    localparam int NUM_PAT  = 28;
    localparam int NUM_RAND = 48;
    localparam int PAT_COLS = 12;
    localparam int PERIOD   = 100;

    logic                           clk;
    logic                           rst_n;
    bitmanip_pkg::rvfi_retire_t     retire;
    bitmanip_pkg::check_t           check;
    logic [bitmanip_pkg::CNT_W-1:0] check_count;
    logic [bitmanip_pkg::CNT_W-1:0] error_count;

    logic [31:0]          pat_mem [0:NUM_PAT*PAT_COLS-1];
    logic [31:0]          rng_state;
    bitmanip_pkg::check_t exp_q [$];
    string                name_q [$];
    bitmanip_pkg::check_t exp_cur;
    string                name_cur;
    logic                 cur_valid = 1'b0;
    int                   value_errors = 0;
    int                   count_errors = 0;
    int                   checks_done = 0;
    int                   exp_checked = 0;
    int                   exp_errors = 0;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bitmanip_spec_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .retire      (retire),
        .check       (check),
        .check_count (check_count),
        .error_count (error_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // the bench numbers its ops 0 pcnt, 1 clz, 2 ctz, 3 andn, 4 orn and 5 xnor.
    function automatic logic [31:0] encode_insn(input int op, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        case (op)
            0:       return {12'h602, rs1, 3'b001, rd, 7'h13};
            1:       return {12'h600, rs1, 3'b001, rd, 7'h13};
            2:       return {12'h601, rs1, 3'b001, rd, 7'h13};
            3:       return {7'h20, rs2, rs1, 3'b111, rd, 7'h33};
            4:       return {7'h20, rs2, rs1, 3'b110, rd, 7'h33};
            default: return {7'h20, rs2, rs1, 3'b100, rd, 7'h33};
        endcase
    endfunction

    function automatic logic [31:0] ref_result(input int op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] v;
        int          n;
        v = a;
        n = 0;
        case (op)
            0: begin
                // clear the lowest set bit until nothing is left.
                while (v != 0) begin
                    v = v & (v - 1);
                    n++;
                end
                return n;
            end
            1: begin
                while (v != 0) begin
                    v = v >> 1;
                    n++;
                end
                return 32 - n;
            end
            2: begin
                if (a == 0) begin
                    return 32;
                end
                while (!v[0]) begin
                    v = v >> 1;
                    n++;
                end
                return n;
            end
            3:       return a & ~b;
            4:       return a | ~b;
            default: return ~(a ^ b);
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic push_expect(input bitmanip_pkg::check_t exp, input string name);
        exp_q.push_back(exp);
        name_q.push_back(name);
        if (exp.checked) begin
            exp_checked++;
        end
        if (exp.mismatch || exp.unknown) begin
            exp_errors++;
        end
    endtask

    task automatic drive_pattern(input int k);
        bitmanip_pkg::rvfi_retire_t rec;
        bitmanip_pkg::check_t       exp;
        int                         base;
        base          = k * PAT_COLS;
        rec.valid     = pat_mem[base][0];
        rec.insn      = pat_mem[base + 1];
        rec.pc_rdata  = pat_mem[base + 2];
        rec.rs1_rdata = pat_mem[base + 3];
        rec.rs2_rdata = pat_mem[base + 4];
        rec.rd_addr   = pat_mem[base + 5][4:0];
        rec.rd_wdata  = pat_mem[base + 6];
        rec.pc_wdata  = pat_mem[base + 7];
        rec.trap      = pat_mem[base + 8][0];
        exp.mismatch  = pat_mem[base + 9][0];
        exp.unknown   = pat_mem[base + 10][0];
        exp.field_err = pat_mem[base + 11][3:0];
        exp.checked   = rec.valid && !exp.unknown;
        @(posedge clk);
        retire <= rec;
        push_expect(exp, $sformatf("pattern %0d", k));
    endtask

    task automatic drive_random(input int idx);
        bitmanip_pkg::rvfi_retire_t rec;
        bitmanip_pkg::check_t       exp;
        logic [31:0]                r;
        logic [31:0]                a;
        logic [31:0]                b;
        logic [31:0]                pc;
        logic [31:0]                want;
        int                         op;
        r    = lcg_next();
        // low generator bits have short periods, so the op comes from the top byte.
        op   = r[31:24] % 6;
        a    = lcg_next() >> r[12:8];
        b    = lcg_next();
        pc   = lcg_next() & 32'hffff_fffc;
        want = (r[20:16] == 5'd0) ? 32'd0 : ref_result(op, a, b);
        rec           = '0;
        rec.valid     = 1'b1;
        rec.insn      = encode_insn(op, r[20:16], r[25:21], r[30:26]);
        rec.pc_rdata  = pc;
        rec.rs1_rdata = a;
        rec.rs2_rdata = b;
        rec.rd_addr   = r[20:16];
        rec.rd_wdata  = want;
        rec.pc_wdata  = pc + 32'd4;
        exp           = '0;
        exp.checked   = 1'b1;
        // every fourth retire is broken in one field, and the broken field rotates over three.
        if (idx % 4 == 3) begin
            exp.mismatch = 1'b1;
            case ((idx / 4) % 3)
                0: begin
                    rec.rd_wdata  = want ^ 32'h1;
                    exp.field_err = 4'b0010;
                end
                1: begin
                    rec.pc_wdata  = pc + 32'd8;
                    exp.field_err = 4'b0100;
                end
                default: begin
                    rec.trap      = 1'b1;
                    exp.field_err = 4'b1000;
                end
            endcase
        end
        @(posedge clk);
        retire <= rec;
        push_expect(exp, $sformatf("random %0d op %0d", idx, op));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // an entry popped on one falling edge is compared on the next one,
    // after the DUT has registered that retire.
    always @(negedge clk) begin
        if (cur_valid) begin
            checks_done++;
            assert (check == exp_cur) else begin
                value_errors++;
                $display("ERROR %s: expected {chk,mis,unk,field_err} %b, actual %b",
                         name_cur, exp_cur, check);
            end
        end
        if (exp_q.size() != 0) begin
            exp_cur   = exp_q.pop_front();
            name_cur  = name_q.pop_front();
            cur_valid = 1'b1;
        end else begin
            cur_valid = 1'b0;
        end
    end

    initial begin
        retire    = '0;
        rng_state = 32'h8f40;
        $readmemh("bench/rvfi_patterns.hex", pat_mem);
        wait (rst_n == 1'b1);
        @(negedge clk);
        assert (check_count == '0 && error_count == '0) else begin
            count_errors++;
            $display("ERROR after_reset: expected counters 0/0, actual %0d/%0d",
                     check_count, error_count);
        end
        for (int k = 0; k < NUM_PAT; k++) begin
            drive_pattern(k);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            drive_random(i);
        end
        @(posedge clk);
        retire <= '0;
        push_expect('0, "drain idle");
        while (exp_q.size() != 0 || cur_valid) begin
            @(posedge clk);
        end
        @(negedge clk);
        assert (int'(check_count) == exp_checked) else begin
            count_errors++;
            $display("ERROR check_count: expected %0d, actual %0d", exp_checked, check_count);
        end
        assert (int'(error_count) == exp_errors) else begin
            count_errors++;
            $display("ERROR error_count: expected %0d, actual %0d", exp_errors, error_count);
        end
        $display("checks %0d, value errors %0d, counter errors %0d",
                 checks_done, value_errors, count_errors);
        if (value_errors == 0 && count_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #((NUM_PAT + NUM_RAND + 20) * PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles",
                 NUM_PAT + NUM_RAND + 20);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset is released on a falling edge so that no rising edge sees it change.
    initial begin
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- src/bitmanip_spec_top.sv
module bitmanip_spec_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  bitmanip_pkg::rvfi_retire_t     retire,
    output bitmanip_pkg::check_t           check,
    output logic [bitmanip_pkg::CNT_W-1:0] check_count,
    output logic [bitmanip_pkg::CNT_W-1:0] error_count
);

    bitmanip_pkg::spec_t pcnt_spec;
    bitmanip_pkg::spec_t zcount_spec;
    bitmanip_pkg::spec_t logic_spec;
    bitmanip_pkg::spec_t spec;
    logic                unknown;

    insn_pcnt_checker u_pcnt (
        .retire (retire),
        .spec   (pcnt_spec)
    );

    insn_zcount_checker u_zcount (
        .retire (retire),
        .spec   (zcount_spec)
    );

    insn_logic_checker u_logic (
        .retire (retire),
        .spec   (logic_spec)
    );

    spec_select u_select (
        .retire      (retire),
        .pcnt_spec   (pcnt_spec),
        .zcount_spec (zcount_spec),
        .logic_spec  (logic_spec),
        .spec        (spec),
        .unknown     (unknown)
    );

    retire_compare u_compare (
        .clk         (clk),
        .rst_n       (rst_n),
        .retire      (retire),
        .spec        (spec),
        .unknown     (unknown),
        .check       (check),
        .check_count (check_count),
        .error_count (error_count)
    );

endmodule

//--- src/retire_compare.sv
module retire_compare (
    input  logic                             clk,
    input  logic                             rst_n,
    input  bitmanip_pkg::rvfi_retire_t       retire,
    input  bitmanip_pkg::spec_t              spec,
    input  logic                             unknown,
    output bitmanip_pkg::check_t             check,
    output logic [bitmanip_pkg::CNT_W-1:0]   check_count,
    output logic [bitmanip_pkg::CNT_W-1:0]   error_count
);

    logic [3:0] field_err;
    logic       mismatch;

    always_comb begin
        field_err = '0;
        if (spec.valid) begin
            field_err[bitmanip_pkg::ERR_RD_ADDR]  = retire.rd_addr  != spec.rd_addr;
            field_err[bitmanip_pkg::ERR_RD_WDATA] = retire.rd_wdata != spec.rd_wdata;
            field_err[bitmanip_pkg::ERR_PC_WDATA] = retire.pc_wdata != spec.pc_wdata;
            field_err[bitmanip_pkg::ERR_TRAP]     = retire.trap     != spec.trap;
        end
    end

    assign mismatch = |field_err;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result pulse and counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            check <= '0;
        end else begin
            check.checked   <= spec.valid;
            check.mismatch  <= mismatch;
            check.unknown   <= unknown;
            check.field_err <= field_err;
        end
    end

    // both counters stick at all ones.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            check_count <= '0;
            error_count <= '0;
        end else begin
            if (spec.valid && check_count != '1) begin
                check_count <= check_count + 1'b1;
            end
            if ((mismatch || unknown) && error_count != '1) begin
                error_count <= error_count + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a retire is either claimed by a spec block or unknown, never both.
    a_claimed_xor_unknown: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(check.checked && check.unknown)
    ) else $error("checked and unknown raised together");

    // an idle retire slot leaves no pulse behind it.
    a_idle_no_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        !retire.valid |=> (check == '0)
    ) else $error("check pulse without a retire");

endmodule

//--- src/spec_select.sv
module spec_select (
    input  bitmanip_pkg::rvfi_retire_t retire,
    input  bitmanip_pkg::spec_t        pcnt_spec,
    input  bitmanip_pkg::spec_t        zcount_spec,
    input  bitmanip_pkg::spec_t        logic_spec,
    output bitmanip_pkg::spec_t        spec,
    output logic                       unknown
);

    logic [2:0]          claim;
    bitmanip_pkg::spec_t pcnt_gated;
    bitmanip_pkg::spec_t zcount_gated;
    bitmanip_pkg::spec_t logic_gated;

    assign claim = {logic_spec.valid, zcount_spec.valid, pcnt_spec.valid};

    // a record that does not claim the retire contributes nothing to the merge.
    assign pcnt_gated   = pcnt_spec.valid   ? pcnt_spec   : '0;
    assign zcount_gated = zcount_spec.valid ? zcount_spec : '0;
    assign logic_gated  = logic_spec.valid  ? logic_spec  : '0;

    assign spec = pcnt_gated | zcount_gated | logic_gated;

    assign unknown = retire.valid && (claim == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the match constants of the three checkers must not overlap, or the
    // or-merge above would blend two results.
    always_comb begin
        a_one_claim: assert final ($onehot0(claim))
            else $error("more than one spec claims insn %h", retire.insn);
    end

endmodule

//--- src/insn_logic_checker.sv
module insn_logic_checker (
    input  bitmanip_pkg::rvfi_retire_t retire,
    output bitmanip_pkg::spec_t        spec
);

    logic                dec_andn;
    logic                dec_orn;
    logic                dec_xnor;
    bitmanip_pkg::xlen_t result;

    assign dec_andn = retire.valid &&
        ((retire.insn & bitmanip_pkg::MASK_RTYPE) == bitmanip_pkg::MATCH_ANDN);
    assign dec_orn  = retire.valid &&
        ((retire.insn & bitmanip_pkg::MASK_RTYPE) == bitmanip_pkg::MATCH_ORN);
    assign dec_xnor = retire.valid &&
        ((retire.insn & bitmanip_pkg::MASK_RTYPE) == bitmanip_pkg::MATCH_XNOR);

    always_comb begin
        case (retire.insn.rtype.funct3)
            3'b111:  result = retire.rs1_rdata & ~retire.rs2_rdata;
            3'b110:  result = retire.rs1_rdata | ~retire.rs2_rdata;
            3'b100:  result = ~(retire.rs1_rdata ^ retire.rs2_rdata);
            default: result = '0;
        endcase
    end

    assign spec.valid    = dec_andn || dec_orn || dec_xnor;
    assign spec.trap     = 1'b0;
    assign spec.rs1_addr = retire.insn.rtype.rs1;
    assign spec.rs2_addr = retire.insn.rtype.rs2;
    assign spec.rd_addr  = retire.insn.rtype.rd;
    assign spec.rd_wdata = (retire.insn.rtype.rd != '0) ? result : '0;
    assign spec.pc_wdata = retire.pc_rdata + 32'd4;

endmodule

//--- src/insn_zcount_checker.sv
module insn_zcount_checker (
    input  bitmanip_pkg::rvfi_retire_t retire,
    output bitmanip_pkg::spec_t        spec
);

    logic                dec_clz;
    logic                dec_ctz;
    bitmanip_pkg::xlen_t lead;
    bitmanip_pkg::xlen_t trail;
    bitmanip_pkg::xlen_t result;

    assign dec_clz = retire.valid &&
        ((retire.insn & bitmanip_pkg::MASK_UNARY) == bitmanip_pkg::MATCH_CLZ);
    assign dec_ctz = retire.valid &&
        ((retire.insn & bitmanip_pkg::MASK_UNARY) == bitmanip_pkg::MATCH_CTZ);

    // the last set bit seen wins, so scanning upward finds the highest one
    // and scanning downward finds the lowest. an all-zero input keeps XLEN.
    always_comb begin
        lead  = bitmanip_pkg::xlen_t'(bitmanip_pkg::XLEN);
        trail = bitmanip_pkg::xlen_t'(bitmanip_pkg::XLEN);
        for (int i = 0; i < bitmanip_pkg::XLEN; i++) begin
            if (retire.rs1_rdata[i]) begin
                lead = bitmanip_pkg::xlen_t'(bitmanip_pkg::XLEN - 1 - i);
            end
        end
        for (int j = bitmanip_pkg::XLEN - 1; j >= 0; j--) begin
            if (retire.rs1_rdata[j]) begin
                trail = bitmanip_pkg::xlen_t'(j);
            end
        end
    end

    // funct12 bit 0 tells ctz from clz.
    assign result = retire.insn.itype.funct12[0] ? trail : lead;

    assign spec.valid    = dec_clz || dec_ctz;
    assign spec.trap     = 1'b0;
    assign spec.rs1_addr = retire.insn.itype.rs1;
    assign spec.rs2_addr = '0;
    assign spec.rd_addr  = retire.insn.itype.rd;
    assign spec.rd_wdata = (retire.insn.itype.rd != '0) ? result : '0;
    assign spec.pc_wdata = retire.pc_rdata + 32'd4;

endmodule

//--- src/insn_pcnt_checker.sv
module insn_pcnt_checker (
    input  bitmanip_pkg::rvfi_retire_t retire,
    output bitmanip_pkg::spec_t        spec
);

    logic                decode;
    bitmanip_pkg::xlen_t result;

    assign decode = retire.valid &&
        ((retire.insn & bitmanip_pkg::MASK_UNARY) == bitmanip_pkg::MATCH_PCNT);

    // population count of rs1 with one adder step per bit.
    always_comb begin
        result = '0;
        for (int i = 0; i < bitmanip_pkg::XLEN; i++) begin
            if (retire.rs1_rdata[i]) begin
                result = result + 1'b1;
            end
        end
    end

    assign spec.valid    = decode;
    // this op never traps.
    assign spec.trap     = 1'b0;
    assign spec.rs1_addr = retire.insn.itype.rs1;
    assign spec.rs2_addr = '0;
    assign spec.rd_addr  = retire.insn.itype.rd;

    // writes to x0 are discarded by the architecture.
    assign spec.rd_wdata = (retire.insn.itype.rd != '0) ? result : '0;
    assign spec.pc_wdata = retire.pc_rdata + 32'd4;

endmodule

//--- src/bitmanip_pkg.sv
package bitmanip_pkg;

    localparam int XLEN  = 32;
    localparam int ILEN  = 32;
    localparam int CNT_W = 16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode matches and decode masks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // unary ops share opcode OP-IMM and funct3 001 and differ only in funct12.
    localparam logic [ILEN-1:0] MASK_UNARY = 32'hfff0707f;
    localparam logic [ILEN-1:0] MATCH_CLZ  = 32'h60001013;
    localparam logic [ILEN-1:0] MATCH_CTZ  = 32'h60101013;
    localparam logic [ILEN-1:0] MATCH_PCNT = 32'h60201013;

    // register-register ops live under opcode OP with funct7 0100000.
    localparam logic [ILEN-1:0] MASK_RTYPE = 32'hfe00707f;
    localparam logic [ILEN-1:0] MATCH_ANDN = 32'h40007033;
    localparam logic [ILEN-1:0] MATCH_ORN  = 32'h40006033;
    localparam logic [ILEN-1:0] MATCH_XNOR = 32'h40004033;

    // bit positions inside check_t.field_err.
    localparam int ERR_RD_ADDR  = 0;
    localparam int ERR_RD_WDATA = 1;
    localparam int ERR_PC_WDATA = 2;
    localparam int ERR_TRAP     = 3;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0] funct12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } itype_t;

    typedef union packed {
        rtype_t rtype;
        itype_t itype;
    } insn_t;

    typedef struct packed {
        logic      valid;
        insn_t     insn;
        xlen_t     pc_rdata;
        xlen_t     rs1_rdata;
        xlen_t     rs2_rdata;
        reg_addr_t rd_addr;
        xlen_t     rd_wdata;
        xlen_t     pc_wdata;
        logic      trap;
    } rvfi_retire_t;

    typedef struct packed {
        logic      valid;
        logic      trap;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        xlen_t     rd_wdata;
        xlen_t     pc_wdata;
    } spec_t;

    typedef struct packed {
        logic       checked;
        logic       mismatch;
        logic       unknown;
        logic [3:0] field_err;
    } check_t;

endpackage
